/* filelist.f */
+incdir+src
src/eai_pkg.sv
src/eai_ctrl.sv
src/eai_row_fetch.sv
src/eai_col_acc.sv
src/eai_rsp_unit.sv
src/eai_core.sv
dv/eai_mem_model.sv
dv/tb_eai_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the matrix coprocessor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_eai_core -f filelist.f -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

if grep -q "=== PASS ===" <<< "$out"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* dv/tb_eai_core.sv */
// testbench for the matrix coprocessor, SETUP, ROWSUM and COLSUM against a shadow memory
// random memory stalls and response back-pressure, stops at the first mismatch
`timescale 1ns/1ps
`include "eai_defs.svh"

module tb_eai_core;

   localparam int TIMEOUT    = 200;
   localparam int MAX_CYCLES = 20000;

   logic                  eai_clk;
   logic                  rst;
   logic                  req_valid;
   eai_pkg::eai_req_t     req;
   logic                  req_ready;
   logic                  rsp_valid;
   eai_pkg::eai_rsp_t     rsp;
   logic                  rsp_ready;
   eai_pkg::eai_mem_cmd_t mem_cmd;
   logic                  mem_cmd_ready;
   eai_pkg::eai_mem_rsp_t mem_rsp;
   logic                  mem_holdup;

   logic [`EAI_XLEN-1:0] shadow [256];
   logic [`EAI_XLEN-1:0] row_start_q [$];
   logic [`EAI_XLEN-1:0] exp_addr_q [$];
   eai_pkg::eai_rsp_t    exp_rsp_q [$];
   logic [`EAI_XLEN-1:0] cur_base;
   logic [`EAI_XLEN-1:0] cur_len;
   eai_pkg::eai_rsp_t    held_rsp;
   logic                 held_valid;
   logic                 rand_ready;
   int                   n_sent;
   int                   n_seen;

   eai_core i_dut (.*);
   eai_mem_model i_mem (.*);

   always #5 eai_clk = ~eai_clk;

   always @(posedge eai_clk) begin
      #1;
      rsp_ready = rand_ready ? ($urandom_range(3, 0) != 0) : 1'b1;
   end

   function automatic logic [`EAI_XLEN-1:0] make_inst(input logic [6:0] f7,
                                                     input logic [2:0] f3,
                                                     input logic [6:0] opc);
      return {f7, 10'd0, f3, 5'd0, opc};
   endfunction

   function automatic logic [`EAI_XLEN-1:0] word_at(input logic [`EAI_XLEN-1:0] addr);
      return shadow[addr[9:2]];
   endfunction

   // sum wraps at 32 bits
   function automatic logic [`EAI_XLEN-1:0] row_sum_ref(input logic [`EAI_XLEN-1:0] start);
      logic [`EAI_XLEN-1:0] sum;
      sum = '0;
      for (int k = 0; k < `EAI_COLS; k++) begin
         sum = sum + word_at(start + 4 * k);
      end
      return sum;
   endfunction

   // rows read since the last row 0
   function automatic logic [`EAI_XLEN-1:0] col_sum_ref(input logic [`EAI_XLEN-1:0] col);
      logic [`EAI_XLEN-1:0] sum;
      sum = '0;
      if (col < `EAI_COLS) begin
         foreach (row_start_q[i]) begin
            sum = sum + word_at(row_start_q[i] + (col << 2));
         end
      end
      return sum;
   endfunction

   task automatic abort_run();
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic report_error(input string msg);
      $display("error at %0t: %s", $time, msg);
      abort_run();
   endtask

   task automatic check_rsp(input string name, input eai_pkg::eai_rsp_t got,
                            input eai_pkg::eai_rsp_t exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h exp %h", $time, name, got.result, exp.result);
         abort_run();
      end
   endtask

   task automatic check_addr(input string name, input logic [`EAI_XLEN-1:0] got,
                             input logic [`EAI_XLEN-1:0] exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic send_req(input logic [`EAI_XLEN-1:0] inst, input logic [`EAI_XLEN-1:0] rs1,
                           input logic [`EAI_XLEN-1:0] rs2);
      int cycles;
      req.inst  = inst;
      req.rs1   = rs1;
      req.rs2   = rs2;
      req_valid = 1'b1;
      cycles    = 0;
      do begin
         @(posedge eai_clk);
         cycles++;
         if (cycles > TIMEOUT) report_error("request was never accepted");
      end while (!req_ready);
      #1;
      req_valid = 1'b0;
   endtask

   // next request is offered at once and waits behind a pending response
   task automatic run_op(input logic [`EAI_XLEN-1:0] inst, input logic [`EAI_XLEN-1:0] rs1,
                         input logic [`EAI_XLEN-1:0] rs2, input logic [`EAI_XLEN-1:0] exp);
      eai_pkg::eai_rsp_t e;
      e.result = exp;
      exp_rsp_q.push_back(e);
      n_sent++;
      send_req(inst, rs1, rs2);
   endtask

   task automatic wait_all_rsp();
      int cycles;
      cycles = 0;
      while (n_seen < n_sent) begin
         @(posedge eai_clk);
         #1;
         cycles++;
         if (cycles > TIMEOUT) report_error("no response from the DUT");
      end
   endtask

   task automatic do_setup(input logic [`EAI_XLEN-1:0] base, input logic [`EAI_XLEN-1:0] len);
      cur_base = base;
      cur_len  = len;
      run_op(make_inst(`EAI_F7_SETUP, `EAI_F3_SETUP, `EAI_OPC_CUSTOM0), base, len, '0);
   endtask

   task automatic do_rowsum(input logic [`EAI_XLEN-1:0] row);
      logic [`EAI_XLEN-1:0] start;
      start = cur_base + row * cur_len * 4;
      if (row == 0) row_start_q.delete();
      row_start_q.push_back(start);
      for (int k = 0; k < `EAI_COLS; k++) begin
         exp_addr_q.push_back(start + 4 * k);
      end
      run_op(make_inst(`EAI_F7_ROWSUM, `EAI_F3_SUM, `EAI_OPC_CUSTOM0), row, '0,
             row_sum_ref(start));
   endtask

   task automatic do_colsum(input logic [`EAI_XLEN-1:0] col);
      run_op(make_inst(`EAI_F7_COLSUM, `EAI_F3_SUM, `EAI_OPC_CUSTOM0), col, '0,
             col_sum_ref(col));
   endtask

   // dropped instructions must leave the DUT quiet
   task automatic send_unknown(input logic [`EAI_XLEN-1:0] inst);
      wait_all_rsp();
      send_req(inst, '0, '0);
      for (int i = 0; i < 20; i++) begin
         @(posedge eai_clk);
         #1;
         if (rsp_valid || mem_cmd.valid) report_error("DUT reacted to an unknown instruction");
      end
   endtask

   ////////////////////
   // compare process
   ////////////////////

   always @(posedge eai_clk) begin
      if (!rst) begin
         if (held_valid) begin
            check_flag("rsp_valid", rsp_valid, 1'b1);
            check_rsp("rsp held", rsp, held_rsp);
         end
         if (req_valid && req_ready && rsp_valid) begin
            report_error("request accepted while a response was pending");
         end
         if (rsp_valid && rsp_ready) begin
            if (exp_rsp_q.size() == 0) report_error("response without a request");
            check_rsp("rsp.result", rsp, exp_rsp_q.pop_front());
            n_seen++;
         end
         held_valid = rsp_valid && !rsp_ready;
         held_rsp   = rsp;
         // a read only happens for a rowsum, and nothing is in flight while idle
         if (mem_cmd.valid) check_flag("mem_holdup", mem_holdup, 1'b1);
         if (req_ready) check_flag("mem_holdup", mem_holdup, 1'b0);
         if (mem_cmd.valid && mem_cmd_ready) begin
            if (exp_addr_q.size() == 0) report_error("read command that was not expected");
            check_addr("mem_cmd.addr", mem_cmd.addr, exp_addr_q.pop_front());
         end
      end
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge eai_clk);
         cycles++;
      end
      report_error("simulation did not finish in time");
   end

   initial begin
      logic [`EAI_XLEN-1:0] w;
      void'($urandom(32'h6ec5));
      eai_clk    = 1'b0;
      rst        = 1'b1;
      req_valid  = 1'b0;
      req        = '0;
      rsp_ready  = 1'b1;
      rand_ready = 1'b0;
      held_valid = 1'b0;
      held_rsp   = '0;
      n_sent     = 0;
      n_seen     = 0;
      for (int i = 0; i < 256; i++) begin
         w                  = $urandom;
         shadow[i[7:0]]     = w;
         i_mem.mem[i[7:0]]  = w;
      end
      repeat (16) @(posedge eai_clk);
      #1;
      rst = 1'b0;
      check_flag("rsp_valid", rsp_valid, 1'b0);
      check_flag("mem_cmd.valid", mem_cmd.valid, 1'b0);
      check_flag("mem_holdup", mem_holdup, 1'b0);
      check_flag("req_ready", req_ready, 1'b1);

      do_setup($urandom_range(63, 0) * 4, $urandom_range(8, 3));
      do_rowsum(0);
      for (int i = 0; i < 5; i++) begin
         do_rowsum($urandom_range(7, 1));
      end
      for (int c = 0; c < 5; c++) begin
         do_colsum(c);
      end
      // row 0 again restarts the totals
      do_rowsum(0);
      do_rowsum($urandom_range(7, 1));
      for (int c = 0; c < 3; c++) begin
         do_colsum(c);
      end

      send_unknown(make_inst(`EAI_F7_SETUP, `EAI_F3_SETUP, 7'b0101011));
      send_unknown(make_inst(7'b0000011, `EAI_F3_SUM, `EAI_OPC_CUSTOM0));
      do_colsum(1);

      rand_ready = 1'b1;
      do_setup($urandom_range(63, 0) * 4, $urandom_range(8, 3));
      for (int i = 0; i < 40; i++) begin
         case ($urandom_range(3, 0))
            0:       do_rowsum(0);
            1, 2:    do_rowsum($urandom_range(7, 1));
            default: do_colsum($urandom_range(4, 0));
         endcase
      end
      for (int c = 0; c < 3; c++) begin
         do_colsum(c);
      end
      wait_all_rsp();
      if (exp_addr_q.size() != 0) report_error("expected read commands never came");
      $display("=== PASS ===");
      $finish;
   end

endmodule

/* dv/eai_mem_model.sv */
// read-only word memory for the testbench, 256 words picked by byte address bits 9:2
// random command stalls, each read answered after a random delay
`timescale 1ns/1ps
`include "eai_defs.svh"

module eai_mem_model (
   input  logic                  eai_clk,
   input  logic                  rst,
   input  eai_pkg::eai_mem_cmd_t mem_cmd,
   output logic                  mem_cmd_ready,
   output eai_pkg::eai_mem_rsp_t mem_rsp
);

   logic [`EAI_XLEN-1:0] mem [256];
   logic [`EAI_XLEN-1:0] rd_data;
   logic                 busy;
   logic                 take;
   logic                 fire;
   int unsigned          delay;

   initial begin
      mem_cmd_ready = 1'b0;
      mem_rsp       = '0;
      busy          = 1'b0;
      delay         = 0;
   end

   // sample on the edge, drive 1 ns later
   always @(posedge eai_clk) begin
      take = mem_cmd.valid && mem_cmd_ready;
      fire = busy && (delay == 0);
      if (busy && delay != 0) begin
         delay = delay - 1;
      end
      if (take) begin
         rd_data = mem[mem_cmd.addr[9:2]];
      end
      #1;
      if (rst) begin
         busy          = 1'b0;
         mem_cmd_ready = 1'b0;
         mem_rsp       = '0;
      end else begin
         mem_rsp.valid = fire;
         mem_rsp.data  = rd_data;
         if (fire) begin
            busy = 1'b0;
         end
         if (take) begin
            busy  = 1'b1;
            delay = $urandom_range(2, 0);
         end
         mem_cmd_ready = ($urandom_range(3, 0) != 0);
      end
   end

endmodule

/* src/eai_core.sv */
// top of the matrix coprocessor on the extension accelerator interface
// controller, row reader, column lanes and response unit
`timescale 1ns/1ps
`include "eai_defs.svh"

module eai_core (
   input  logic                   eai_clk,
   input  logic                   rst,
   input  logic                   req_valid,
   input  eai_pkg::eai_req_t      req,
   output logic                   req_ready,
   output logic                   rsp_valid,
   output eai_pkg::eai_rsp_t      rsp,
   input  logic                   rsp_ready,
   output eai_pkg::eai_mem_cmd_t  mem_cmd,
   input  logic                   mem_cmd_ready,
   input  eai_pkg::eai_mem_rsp_t  mem_rsp,
   output logic                   mem_holdup
);

   eai_pkg::eai_job_t    job;
   eai_pkg::col_beat_t   beat;
   logic                 row_done;
   logic [`EAI_XLEN-1:0] totals [`EAI_COLS];

   eai_ctrl i_ctrl (
      .eai_clk    (eai_clk),
      .rst        (rst),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .job        (job),
      .mem_holdup (mem_holdup)
   );

   eai_row_fetch i_row_fetch (
      .eai_clk       (eai_clk),
      .rst           (rst),
      .job           (job),
      .mem_cmd       (mem_cmd),
      .mem_cmd_ready (mem_cmd_ready),
      .mem_rsp       (mem_rsp),
      .beat          (beat),
      .row_done      (row_done)
   );

   // one lane per column
   for (genvar g = 0; g < `EAI_COLS; g++) begin : g_lane
      eai_col_acc #(.LANE(g)) i_col_acc (
         .eai_clk (eai_clk),
         .rst     (rst),
         .beat    (beat),
         .total   (totals[g])
      );
   end

   eai_rsp_unit i_rsp_unit (
      .eai_clk   (eai_clk),
      .rst       (rst),
      .job       (job),
      .beat      (beat),
      .row_done  (row_done),
      .totals    (totals),
      .rsp_valid (rsp_valid),
      .rsp       (rsp),
      .rsp_ready (rsp_ready)
   );

endmodule

/* src/eai_rsp_unit.sv */
// response data and valid; held until rsp_ready is seen
`timescale 1ns/1ps
`include "eai_defs.svh"

module eai_rsp_unit (
   input  logic                 eai_clk,
   input  logic                 rst,
   input  eai_pkg::eai_job_t    job,
   input  eai_pkg::col_beat_t   beat,
   input  logic                 row_done,
   input  logic [`EAI_XLEN-1:0] totals [`EAI_COLS],
   output logic                 rsp_valid,
   output eai_pkg::eai_rsp_t    rsp,
   input  logic                 rsp_ready
);

   logic [`EAI_XLEN-1:0] row_sum;
   logic [`EAI_XLEN-1:0] col_total;
   logic                 setup_job;
   logic                 rowsum_job;
   logic                 colsum_job;

   assign setup_job  = job.valid && (job.op == eai_pkg::OP_SETUP);
   assign rowsum_job = job.valid && (job.op == eai_pkg::OP_ROWSUM);
   assign colsum_job = job.valid && (job.op == eai_pkg::OP_COLSUM);

   // out of range index reads as 0
   always_comb begin
      col_total = '0;
      for (int i = 0; i < `EAI_COLS; i++) begin
         if (job.arg_a == i) begin
            col_total = totals[i];
         end
      end
   end

   always_ff @(posedge eai_clk) begin
      if (rowsum_job) begin
         row_sum <= '0;
      end else if (beat.valid) begin
         row_sum <= row_sum + beat.data;
      end
   end

   // last word arrives with row_done, fold it in here
   always_ff @(posedge eai_clk) begin
      if (setup_job) begin
         rsp.result <= '0;
      end else if (colsum_job) begin
         rsp.result <= col_total;
      end else if (row_done) begin
         rsp.result <= row_sum + beat.data;
      end
      if (rst) begin
         rsp_valid <= 1'b0;
      end else if (setup_job || colsum_job || row_done) begin
         rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
         rsp_valid <= 1'b0;
      end
   end

   rsp_held: assert property (@(posedge eai_clk) disable iff (rst)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp.result));

endmodule

/* src/eai_col_acc.sv */
// one column lane, keeps the running total of its column
`timescale 1ns/1ps
`include "eai_defs.svh"

module eai_col_acc #(
   parameter int LANE = 0
) (
   input  logic                 eai_clk,
   input  logic                 rst,
   input  eai_pkg::col_beat_t   beat,
   output logic [`EAI_XLEN-1:0] total
);

   localparam logic [`EAI_COL_IDX_W-1:0] LANE_IDX = LANE[`EAI_COL_IDX_W-1:0];

   logic hit;

   assign hit = beat.valid && (beat.col == LANE_IDX);

   // row 0 starts a new total
   always_ff @(posedge eai_clk) begin
      if (rst) begin
         total <= '0;
      end else if (hit) begin
         if (beat.first_row) begin
            total <= beat.data;
         end else begin
            total <= total + beat.data;
         end
      end
   end

endmodule

/* src/eai_row_fetch.sv */
// setup registers and row reader; one word read outstanding at a time
// every returned word goes out as a beat tagged with its column
`timescale 1ns/1ps
`include "eai_defs.svh"

module eai_row_fetch (
   input  logic                   eai_clk,
   input  logic                   rst,
   input  eai_pkg::eai_job_t      job,
   output eai_pkg::eai_mem_cmd_t  mem_cmd,
   input  logic                   mem_cmd_ready,
   input  eai_pkg::eai_mem_rsp_t  mem_rsp,
   output eai_pkg::col_beat_t     beat,
   output logic                   row_done
);

   logic [`EAI_XLEN-1:0]      base_r;
   logic [`EAI_XLEN-1:0]      len_r;
   logic [`EAI_XLEN-1:0]      row_addr;
   logic [`EAI_COL_IDX_W-1:0] col_r;
   logic                      first_row_r;
   logic                      rd_pend;
   logic                      setup_job;
   logic                      rowsum_job;
   logic                      rd_take;
   logic                      last_col;

   assign setup_job  = job.valid && (job.op == eai_pkg::OP_SETUP);
   assign rowsum_job = job.valid && (job.op == eai_pkg::OP_ROWSUM);
   // row length is in words
   assign row_addr   = base_r + ((job.arg_a * len_r) << 2);
   assign rd_take    = rd_pend && mem_rsp.valid;
   assign last_col   = (col_r == `EAI_COL_IDX_W'(`EAI_COLS - 1));

   always_ff @(posedge eai_clk) begin
      if (setup_job) begin
         base_r <= job.arg_a;
         len_r  <= job.arg_b;
      end
   end

   ////////////////////
   // read command
   ////////////////////

   always_ff @(posedge eai_clk) begin
      if (rowsum_job) begin
         mem_cmd.addr <= row_addr;
         first_row_r  <= (job.arg_a == '0);
      end else if (rd_take && !last_col) begin
         mem_cmd.addr <= mem_cmd.addr + `EAI_XLEN'd4;
      end
      if (rst) begin
         mem_cmd.valid <= 1'b0;
         rd_pend       <= 1'b0;
         col_r         <= '0;
      end else begin
         if (rowsum_job || (rd_take && !last_col)) begin
            mem_cmd.valid <= 1'b1;
         end else if (mem_cmd.valid && mem_cmd_ready) begin
            mem_cmd.valid <= 1'b0;
         end
         if (mem_cmd.valid && mem_cmd_ready) begin
            rd_pend <= 1'b1;
         end else if (rd_take) begin
            rd_pend <= 1'b0;
         end
         if (rowsum_job) begin
            col_r <= '0;
         end else if (rd_take) begin
            col_r <= col_r + 1'b1;
         end
      end
   end

   // beat and row_done leave together on the last word
   always_ff @(posedge eai_clk) begin
      beat.col       <= col_r;
      beat.first_row <= first_row_r;
      beat.data      <= mem_rsp.data;
      if (rst) begin
         beat.valid <= 1'b0;
         row_done   <= 1'b0;
      end else begin
         beat.valid <= rd_take;
         row_done   <= rd_take && last_col;
      end
   end

   cmd_addr_held: assert property (@(posedge eai_clk) disable iff (rst)
      mem_cmd.valid && !mem_cmd_ready |=> mem_cmd.valid && $stable(mem_cmd.addr));

endmodule

/* src/eai_ctrl.sv */
// instruction decode and busy FSM of the matrix coprocessor
// one job per accepted custom-0 instruction; idle again after the response is taken
`timescale 1ns/1ps
`include "eai_defs.svh"

module eai_ctrl (
   input  logic               eai_clk,
   input  logic               rst,
   input  logic               req_valid,
   input  eai_pkg::eai_req_t  req,
   output logic               req_ready,
   input  logic               rsp_valid,
   input  logic               rsp_ready,
   output eai_pkg::eai_job_t  job,
   output logic               mem_holdup
);

   eai_pkg::eai_state_e state;
   eai_pkg::eai_op_e    dec_op;
   logic [6:0]          opc;
   logic [2:0]          f3;
   logic [6:0]          f7;
   logic                req_xfer;
   logic                rsp_xfer;

   assign opc      = req.inst[6:0];
   assign f3       = req.inst[14:12];
   assign f7       = req.inst[31:25];
   assign req_xfer = req_valid && req_ready;
   assign rsp_xfer = rsp_valid && rsp_ready;

   // anything else decodes to OP_NONE and is dropped
   always_comb begin
      dec_op = eai_pkg::OP_NONE;
      if (opc == `EAI_OPC_CUSTOM0) begin
         if (f3 == `EAI_F3_SETUP && f7 == `EAI_F7_SETUP) begin
            dec_op = eai_pkg::OP_SETUP;
         end else if (f3 == `EAI_F3_SUM && f7 == `EAI_F7_ROWSUM) begin
            dec_op = eai_pkg::OP_ROWSUM;
         end else if (f3 == `EAI_F3_SUM && f7 == `EAI_F7_COLSUM) begin
            dec_op = eai_pkg::OP_COLSUM;
         end
      end
   end

   always_ff @(posedge eai_clk) begin
      if (rst) begin
         state <= eai_pkg::ST_IDLE;
      end else if (state == eai_pkg::ST_IDLE) begin
         if (req_xfer && dec_op != eai_pkg::OP_NONE) begin
            state <= eai_pkg::ST_BUSY;
         end
      end else if (rsp_xfer) begin
         state <= eai_pkg::ST_IDLE;
      end
   end

   // op stays put while busy, mem_holdup reads it
   always_ff @(posedge eai_clk) begin
      if (req_xfer && dec_op != eai_pkg::OP_NONE) begin
         job.op    <= dec_op;
         job.arg_a <= req.rs1;
         job.arg_b <= req.rs2;
      end
      if (rst) begin
         job.valid <= 1'b0;
      end else begin
         job.valid <= req_xfer && (dec_op != eai_pkg::OP_NONE);
      end
   end

   assign req_ready  = (state == eai_pkg::ST_IDLE);
   assign mem_holdup = (state == eai_pkg::ST_BUSY) && (job.op == eai_pkg::OP_ROWSUM);

   // no new instruction while the response unit still holds one
   req_only_when_free: assert property (@(posedge eai_clk) disable iff (rst)
      req_xfer |-> (state == eai_pkg::ST_IDLE) && !rsp_valid);

endmodule

/* src/eai_pkg.sv */
// types shared by the matrix coprocessor RTL and its testbench
`include "eai_defs.svh"

package eai_pkg;

   typedef enum logic [1:0] {
      OP_NONE,
      OP_SETUP,
      OP_ROWSUM,
      OP_COLSUM
   } eai_op_e;

   typedef enum logic {
      ST_IDLE,
      ST_BUSY
   } eai_state_e;

   ////////////////////
   // bus and internal payloads
   ////////////////////

   typedef struct packed {
      logic [`EAI_XLEN-1:0] inst;
      logic [`EAI_XLEN-1:0] rs1;
      logic [`EAI_XLEN-1:0] rs2;
   } eai_req_t;

   // arg_a is rs1, arg_b is rs2
   typedef struct packed {
      logic                 valid;
      eai_op_e              op;
      logic [`EAI_XLEN-1:0] arg_a;
      logic [`EAI_XLEN-1:0] arg_b;
   } eai_job_t;

   typedef struct packed {
      logic                 valid;
      logic [`EAI_XLEN-1:0] addr;
   } eai_mem_cmd_t;

   typedef struct packed {
      logic                 valid;
      logic [`EAI_XLEN-1:0] data;
   } eai_mem_rsp_t;

   typedef struct packed {
      logic                      valid;
      logic [`EAI_COL_IDX_W-1:0] col;
      logic                      first_row;
      logic [`EAI_XLEN-1:0]      data;
   } col_beat_t;

   typedef struct packed {
      logic [`EAI_XLEN-1:0] result;
   } eai_rsp_t;

endpackage

/* src/eai_defs.svh */
// widths and custom-0 instruction field values for the matrix coprocessor
// include wherever a width, the column count or an encoding is needed
`ifndef EAI_DEFS_SVH
`define EAI_DEFS_SVH

// datapath and address width
`define EAI_XLEN        32

// one row is three words wide
`define EAI_COLS        3
`define EAI_COL_IDX_W   2

// custom-0 major opcode
`define EAI_OPC_CUSTOM0 7'b0001011

// func3 groups
`define EAI_F3_SETUP    3'b011
`define EAI_F3_SUM      3'b110

// func7 picks the operation inside a func3 group
`define EAI_F7_SETUP    7'b0000000
`define EAI_F7_ROWSUM   7'b0000001
`define EAI_F7_COLSUM   7'b0000010

`endif
